/* common/ctrlUnit_cfg.svh */
`ifndef CTRL_UNIT_CFG_SVH
`define CTRL_UNIT_CFG_SVH

`define CU_WORD_W       32      // Instruction word width
`define CU_STEP_W       3       // Step counter width

`define CU_DP_STEPS     1       // Data processing execute steps
`define CU_LOAD_STEPS   2       // Address steps ahead of load memory wait
`define CU_STORE_STEPS  3       // Address steps ahead of store memory wait
`define CU_B_STEPS      1       // Branch
`define CU_BL_STEPS     2       // Link write, then PC write

`define CU_OP_TST       4'b1000 // Test group opcodes
`define CU_OP_TEQ       4'b1001

`define CU_CLASS_LSB    25      // Format field is [27:25]
`define CU_OP_LSB       21      // Opcode field is [24:21]
`define CU_SBIT         20      // S bit, also L bit of load/store
`define CU_PBIT         24      // Pre-index, also link bit of branch
`define CU_UBIT         23      // Add offset
`define CU_BBIT         22      // Byte access
`define CU_WBIT         21      // Base write-back
`define CU_SHREG_BIT    4       // Set for register-specified shift

`endif

/* common/ctrlPkg.sv */
`include "ctrlUnit_cfg.svh"

package ctrlPkg;

	typedef logic [`CU_WORD_W-1:0] instrWord_t;    // Fetched instruction
	typedef logic [`CU_STEP_W-1:0] stepCount_t;    // Remaining execute steps
	typedef logic [2:0]            fmtField_t;     // Format bits [27:25]
	typedef logic [3:0]            opcode_t;       // Data processing opcode

	// Sequencer phases, one fetch/decode/execute pass per instruction
	typedef enum logic [2:0] {
		phReset,
		phFetchAddr,
		phFetchReq,
		phFetchWait,    // Held until moc
		phDecode,
		phExec,         // Runs for execSteps cycles
		phMemWait,      // Load/store data access
		phWriteback     // Loads only
	} ctrlPhase_t;

	typedef enum logic [2:0] {
		clsDataImm,     // Immediate operand
		clsDataReg,     // Register shifted by immediate
		clsDataTest,    // Flags only
		clsLoad,
		clsStore,
		clsBranch,
		clsBranchLink,
		clsUnsupported
	} instrClass_t;

endpackage

/* hdl/controlSequencer.sv */
`timescale 1ns/10ps

module controlSequencer (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 moc,
	input  logic                 cond,
	input  ctrlPkg::instrClass_t instrClass,
	input  logic                 lastStep,
	output ctrlPkg::ctrlPhase_t  phase,
	output logic                 stepLoad,
	output logic                 stepEn,
	output logic                 skipped,
	output logic                 badInstr
);

	ctrlPkg::ctrlPhase_t nextPhase;
	logic                isMemClass;

	assign isMemClass = (instrClass == ctrlPkg::clsLoad) ||
		(instrClass == ctrlPkg::clsStore);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			phase <= ctrlPkg::phReset;
		end else begin
			phase <= nextPhase;
		end
	end

	// Decode outcome, condition checked ahead of the class
	assign skipped  = (phase == ctrlPkg::phDecode) && !cond;
	assign badInstr = (phase == ctrlPkg::phDecode) && cond &&
		(instrClass == ctrlPkg::clsUnsupported);
	assign stepLoad = (phase == ctrlPkg::phDecode) && cond &&
		(instrClass != ctrlPkg::clsUnsupported);
	assign stepEn   = (phase == ctrlPkg::phExec);

	always_comb begin
		nextPhase = phase;     // Hold by default
		case (phase)
			ctrlPkg::phReset:     nextPhase = ctrlPkg::phFetchAddr;
			ctrlPkg::phFetchAddr: nextPhase = ctrlPkg::phFetchReq;
			ctrlPkg::phFetchReq:  nextPhase = ctrlPkg::phFetchWait;
			ctrlPkg::phFetchWait: begin
				if (moc) begin
					nextPhase = ctrlPkg::phDecode;
				end
			end
			ctrlPkg::phDecode: begin
				if (stepLoad) begin
					nextPhase = ctrlPkg::phExec;
				end else begin
					nextPhase = ctrlPkg::phFetchAddr;   // Skipped or bad
				end
			end
			ctrlPkg::phExec: begin
				if (lastStep) begin
					nextPhase = isMemClass ? ctrlPkg::phMemWait : ctrlPkg::phFetchAddr;
				end
			end
			ctrlPkg::phMemWait: begin
				if (moc) begin
					// Only a load has data to write back
					if (instrClass == ctrlPkg::clsLoad) begin
						nextPhase = ctrlPkg::phWriteback;
					end else begin
						nextPhase = ctrlPkg::phFetchAddr;
					end
				end
			end
			ctrlPkg::phWriteback: nextPhase = ctrlPkg::phFetchAddr;
			default:              nextPhase = ctrlPkg::phFetchAddr;
		endcase
	end

endmodule

/* hdl/stepCounter.sv */
`timescale 1ns/10ps

module stepCounter (
	input  logic                clk,
	input  logic                rstN,
	input  logic                stepLoad,
	input  logic                stepEn,
	input  ctrlPkg::stepCount_t execSteps,
	output logic                lastStep
);

	ctrlPkg::stepCount_t count;    // Steps left, current one included

	always_ff @(posedge clk) begin
		if (!rstN) begin
			count <= '0;
		end else if (stepLoad) begin
			count <= execSteps;
		end else if (stepEn && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

	// Valid in the same cycle as the count
	assign lastStep = (count == ctrlPkg::stepCount_t'(1));

endmodule

/* decode/instrDecoder.sv */
`timescale 1ns/10ps
`include "ctrlUnit_cfg.svh"

module instrDecoder (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 irLoad,
	input  ctrlPkg::instrWord_t  instrWord,
	output ctrlPkg::instrClass_t instrClass,
	output logic                 setFlags,
	output logic                 byteAccess,
	output logic                 addOffset,
	output logic                 writeBack,
	output ctrlPkg::stepCount_t  execSteps
);

	ctrlPkg::instrWord_t ir;
	ctrlPkg::fmtField_t  fmt;
	ctrlPkg::opcode_t    opcode;
	logic                isTest;
	logic                shiftByReg;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ir <= '0;
		end else if (irLoad) begin
			ir <= instrWord;
		end
	end

	assign fmt        = ir[`CU_CLASS_LSB+2:`CU_CLASS_LSB];
	assign opcode     = ir[`CU_OP_LSB+3:`CU_OP_LSB];
	assign isTest     = (opcode == `CU_OP_TST) || (opcode == `CU_OP_TEQ);
	assign shiftByReg = ir[`CU_SHREG_BIT];

	// Format table, anything not listed is reported as bad
	always_comb begin
		case (fmt)
			3'b000: begin
				if (shiftByReg) begin
					instrClass = ctrlPkg::clsUnsupported;   // Register shift, extra ld/st
				end else begin
					instrClass = isTest ? ctrlPkg::clsDataTest : ctrlPkg::clsDataReg;
				end
			end
			3'b001: instrClass = isTest ? ctrlPkg::clsDataTest : ctrlPkg::clsDataImm;
			3'b010: instrClass = ir[`CU_SBIT] ? ctrlPkg::clsLoad : ctrlPkg::clsStore;
			3'b011: begin
				if (shiftByReg) begin
					instrClass = ctrlPkg::clsUnsupported;   // Media space
				end else begin
					instrClass = ir[`CU_SBIT] ? ctrlPkg::clsLoad : ctrlPkg::clsStore;
				end
			end
			3'b101: instrClass = ir[`CU_PBIT] ? ctrlPkg::clsBranchLink : ctrlPkg::clsBranch;
			default: instrClass = ctrlPkg::clsUnsupported;  // LDM/STM and the rest
		endcase
	end

	assign setFlags   = ir[`CU_SBIT];
	assign byteAccess = ir[`CU_BBIT];
	assign addOffset  = ir[`CU_UBIT];

	// Post-indexed always updates the base, pre-indexed only with W
	assign writeBack  = !ir[`CU_PBIT] || ir[`CU_WBIT];

	always_comb begin
		case (instrClass)
			ctrlPkg::clsDataImm,
			ctrlPkg::clsDataReg,
			ctrlPkg::clsDataTest:   execSteps = ctrlPkg::stepCount_t'(`CU_DP_STEPS);
			ctrlPkg::clsLoad:       execSteps = ctrlPkg::stepCount_t'(`CU_LOAD_STEPS);
			ctrlPkg::clsStore:      execSteps = ctrlPkg::stepCount_t'(`CU_STORE_STEPS);
			ctrlPkg::clsBranch:     execSteps = ctrlPkg::stepCount_t'(`CU_B_STEPS);
			ctrlPkg::clsBranchLink: execSteps = ctrlPkg::stepCount_t'(`CU_BL_STEPS);
			default:                execSteps = '0;     // Never executed
		endcase
	end

endmodule

/* hdl/microOpGen.sv */
`timescale 1ns/10ps

module microOpGen (
	input  ctrlPkg::ctrlPhase_t  phase,
	input  ctrlPkg::instrClass_t instrClass,
	input  logic                 setFlags,
	input  logic                 writeBack,
	input  logic                 lastStep,
	input  logic                 moc,
	output logic                 memRead,
	output logic                 memWrite,
	output logic                 irLoad,
	output logic                 regWrite,
	output logic                 flagWrite,
	output logic                 baseWrite,
	output logic                 pcWrite,
	output logic                 linkWrite,
	output logic                 instrDone
);

	logic inExec;
	logic inMemWait;
	logic isLoad;
	logic isStore;
	logic isAluWrite;     // Data processing with a destination register
	logic isBranch;
	logic memDone;

	assign inExec     = (phase == ctrlPkg::phExec);
	assign inMemWait  = (phase == ctrlPkg::phMemWait);
	assign isLoad     = (instrClass == ctrlPkg::clsLoad);
	assign isStore    = (instrClass == ctrlPkg::clsStore);
	assign isAluWrite = (instrClass == ctrlPkg::clsDataImm) ||
		(instrClass == ctrlPkg::clsDataReg);
	assign isBranch   = (instrClass == ctrlPkg::clsBranch) ||
		(instrClass == ctrlPkg::clsBranchLink);
	assign memDone    = inMemWait && moc;

	assign memRead   = (phase == ctrlPkg::phFetchReq) || (phase == ctrlPkg::phFetchWait) ||
		(inMemWait && isLoad);
	assign memWrite  = inMemWait && isStore;
	assign irLoad    = (phase == ctrlPkg::phFetchWait) && moc;     // Latch fetched word

	assign regWrite  = (inExec && isAluWrite) || (phase == ctrlPkg::phWriteback);
	assign flagWrite = inExec &&
		((instrClass == ctrlPkg::clsDataTest) || (isAluWrite && setFlags));
	assign baseWrite = memDone && writeBack;

	// BL runs two steps, link goes first
	assign linkWrite = inExec && !lastStep && (instrClass == ctrlPkg::clsBranchLink);
	assign pcWrite   = inExec && lastStep && isBranch;

	assign instrDone = (inExec && lastStep && !isLoad && !isStore) ||
		(memDone && isStore) || (phase == ctrlPkg::phWriteback);

endmodule

/* hdl/ctrlUnit.sv */
`timescale 1ns/10ps

module ctrlUnit (
	input  logic               clk,
	input  logic               rstN,
	input  ctrlPkg::instrWord_t instrWord,
	input  logic               moc,
	input  logic               cond,
	output ctrlPkg::ctrlPhase_t phase,
	output ctrlPkg::instrClass_t instrClass,
	output logic               memRead,
	output logic               memWrite,
	output logic               irLoad,
	output logic               regWrite,
	output logic               flagWrite,
	output logic               baseWrite,
	output logic               pcWrite,
	output logic               linkWrite,
	output logic               byteAccess,
	output logic               addOffset,
	output logic               instrDone,
	output logic               skipped,
	output logic               badInstr
);

	logic                stepLoad;
	logic                stepEn;
	logic                lastStep;
	logic                setFlags;
	logic                writeBack;
	ctrlPkg::stepCount_t execSteps;

	controlSequencer controlSequencer_i (
		.clk(clk), .rstN(rstN), .moc(moc), .cond(cond), .instrClass(instrClass),
		.lastStep(lastStep), .phase(phase), .stepLoad(stepLoad), .stepEn(stepEn),
		.skipped(skipped), .badInstr(badInstr)
	);

	stepCounter stepCounter_i (
		.clk(clk), .rstN(rstN), .stepLoad(stepLoad), .stepEn(stepEn),
		.execSteps(execSteps), .lastStep(lastStep)
	);

	instrDecoder instrDecoder_i (
		.clk(clk), .rstN(rstN), .irLoad(irLoad), .instrWord(instrWord),
		.instrClass(instrClass), .setFlags(setFlags), .byteAccess(byteAccess),
		.addOffset(addOffset), .writeBack(writeBack), .execSteps(execSteps)
	);

	microOpGen microOpGen_i (
		.phase(phase), .instrClass(instrClass), .setFlags(setFlags),
		.writeBack(writeBack), .lastStep(lastStep), .moc(moc),
		.memRead(memRead), .memWrite(memWrite), .irLoad(irLoad),
		.regWrite(regWrite), .flagWrite(flagWrite), .baseWrite(baseWrite),
		.pcWrite(pcWrite), .linkWrite(linkWrite), .instrDone(instrDone)
	);

endmodule

/* dv/tbClock.sv */
`timescale 1ns/10ps

module tbClock (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;    // 4 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		#1 rstN = 1'b1;           // Released on the stimulus offset
	end

endmodule

/* dv/ctrlUnit_sva.sv */
`timescale 1ns/10ps

module ctrlUnit_sva (
	input logic                clk,
	input logic                rstN,
	input ctrlPkg::ctrlPhase_t phase,
	input logic                memRead,
	input logic                memWrite,
	input logic                pcWrite,
	input logic                skipped,
	input logic                badInstr
);

	memExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(memRead && memWrite))
		else $error("memRead and memWrite high in the same cycle");

	badToFetch: assert property (@(posedge clk) disable iff (!rstN)
		badInstr |=> (phase == ctrlPkg::phFetchAddr))
		else $error("badInstr not followed by phFetchAddr");

	skipToFetch: assert property (@(posedge clk) disable iff (!rstN)
		skipped |=> (phase == ctrlPkg::phFetchAddr))
		else $error("skipped not followed by phFetchAddr");

	pcWriteInExec: assert property (@(posedge clk) disable iff (!rstN)
		pcWrite |-> (phase == ctrlPkg::phExec))
		else $error("pcWrite outside phExec");

endmodule

/* dv/ctrlUnitTb.sv */
`timescale 1ns/10ps
`include "ctrlUnit_cfg.svh"

module ctrlUnitTb;

	localparam int instrWorst = 19;     // Fetch 8, decode 1, exec 3, memory wait 6, writeback 1
	localparam int numInstr   = 31;
	localparam int timeoutNs  = 2 * (18 + numInstr * instrWorst) * 4;

	logic                 clk;
	logic                 rstN;
	ctrlPkg::instrWord_t  instrWord;
	logic                 moc;
	logic                 cond;
	ctrlPkg::ctrlPhase_t  phase;
	ctrlPkg::instrClass_t instrClass;
	logic                 memRead;
	logic                 memWrite;
	logic                 irLoad;
	logic                 regWrite;
	logic                 flagWrite;
	logic                 baseWrite;
	logic                 pcWrite;
	logic                 linkWrite;
	logic                 byteAccess;
	logic                 addOffset;
	logic                 instrDone;
	logic                 skipped;
	logic                 badInstr;
	logic [10:0]          strobeVec;
	int                   errorCount = 0;
	int                   testsRun = 0;
	int                   testsFailed = 0;
	string strobeNames[11] = '{"memRead", "memWrite", "irLoad", "regWrite", "flagWrite",
		"baseWrite", "pcWrite", "linkWrite", "instrDone", "skipped", "badInstr"};

	assign strobeVec = {badInstr, skipped, instrDone, linkWrite, pcWrite, baseWrite,
		flagWrite, regWrite, irLoad, memWrite, memRead};

	tbClock tbClock_i (.clk(clk), .rstN(rstN));

	ctrlUnit ctrlUnit_i (.*);

	bind ctrlUnit ctrlUnit_sva ctrlUnitSva_i (.clk(clk), .rstN(rstN), .phase(phase),
		.memRead(memRead), .memWrite(memWrite), .pcWrite(pcWrite), .skipped(skipped),
		.badInstr(badInstr));

	task automatic compareBit(input string sig, input logic got, input logic exp);
		if (got !== exp) begin
			errorCount++;
			$display("error: %s got 0x%0h expected 0x%0h", sig, got, exp);
		end
	endtask

	task automatic compareClass(input string sig, input ctrlPkg::instrClass_t got,
		input ctrlPkg::instrClass_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("error: %s got 0x%0h expected 0x%0h", sig, got, exp);
		end
	endtask

	task automatic comparePhase(input string sig, input ctrlPkg::ctrlPhase_t got,
		input ctrlPkg::ctrlPhase_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("error: %s got 0x%0h expected 0x%0h", sig, got, exp);
		end
	endtask

	task automatic compareCount(input string sig, input int got, input int exp);
		if (got != exp) begin
			errorCount++;
			$display("error: %s got 0x%0h expected 0x%0h", sig, got, exp);
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		if (errorCount == errBefore) begin
			$display("%s: pass", name);
		end else begin
			testsFailed++;
			$display("%s: %0d errors", name, errorCount - errBefore);
		end
	endtask

	function automatic int stepsFor(input ctrlPkg::instrClass_t cls);
		case (cls)
			ctrlPkg::clsLoad:       return `CU_LOAD_STEPS;
			ctrlPkg::clsStore:      return `CU_STORE_STEPS;
			ctrlPkg::clsBranch:     return `CU_B_STEPS;
			ctrlPkg::clsBranchLink: return `CU_BL_STEPS;
			default:                return `CU_DP_STEPS;
		endcase
	endfunction

	// One instruction from phFetchAddr to its final cycle
	task automatic runInstr(input ctrlPkg::instrWord_t word, input logic condVal,
		input ctrlPkg::instrClass_t expCls);
		int fetchDelay;
		int memDelay;
		int waitCnt;
		int cyc;
		int linkAt;
		int pcAt;
		int gotPh[8];
		int expPh[8];
		int got[11];
		int exp[11];
		logic isMem;
		logic done;
		ctrlPkg::ctrlPhase_t ph;
		fetchDelay = $urandom_range(5);
		memDelay = $urandom_range(5);
		isMem = (expCls == ctrlPkg::clsLoad) || (expCls == ctrlPkg::clsStore);
		gotPh = '{default: 0};
		expPh = '{default: 0};
		got = '{default: 0};
		exp = '{default: 0};
		expPh[int'(ctrlPkg::phFetchAddr)] = 1;
		expPh[int'(ctrlPkg::phFetchReq)] = 1;
		expPh[int'(ctrlPkg::phFetchWait)] = fetchDelay + 1;
		expPh[int'(ctrlPkg::phDecode)] = 1;
		exp[0] = fetchDelay + 2;
		exp[2] = 1;
		if (!condVal) begin
			exp[9] = 1;
		end else if (expCls == ctrlPkg::clsUnsupported) begin
			exp[10] = 1;
		end else begin
			expPh[int'(ctrlPkg::phExec)] = stepsFor(expCls);
			exp[8] = 1;
			case (expCls)
				ctrlPkg::clsDataImm, ctrlPkg::clsDataReg: begin
					exp[3] = 1;
					exp[4] = int'(word[`CU_SBIT]);
				end
				ctrlPkg::clsDataTest: exp[4] = 1;
				ctrlPkg::clsLoad: begin
					exp[0] += memDelay + 1;
					exp[3] = 1;
					expPh[int'(ctrlPkg::phWriteback)] = 1;
				end
				ctrlPkg::clsStore:      exp[1] = memDelay + 1;
				ctrlPkg::clsBranch:     exp[6] = 1;
				ctrlPkg::clsBranchLink: begin
					exp[6] = 1;
					exp[7] = 1;
				end
				default: ;
			endcase
			if (isMem) begin
				expPh[int'(ctrlPkg::phMemWait)] = memDelay + 1;
				// Pre-indexed with W, or post-indexed
				exp[5] = int'((word[`CU_PBIT] && word[`CU_WBIT]) || !word[`CU_PBIT]);
			end
		end
		done = 1'b0;
		cyc = 0;
		waitCnt = 0;
		linkAt = -1;
		pcAt = -1;
		while (!done) begin
			@(posedge clk);
			#1;
			instrWord = word;
			cond = condVal;
			if (phase == ctrlPkg::phFetchWait) begin
				moc = (waitCnt == fetchDelay);
			end else if (phase == ctrlPkg::phMemWait) begin
				moc = (waitCnt == memDelay);
			end else begin
				moc = 1'b0;
			end
			#1;
			if (cyc == 0) begin
				comparePhase("phase", phase, ctrlPkg::phFetchAddr);
			end
			if (phase == ctrlPkg::phDecode) begin
				compareClass("instrClass", instrClass, expCls);
			end
			if ((phase == ctrlPkg::phExec) && isMem) begin
				compareBit("byteAccess", byteAccess, word[`CU_BBIT]);
				compareBit("addOffset", addOffset, word[`CU_UBIT]);
			end
			gotPh[int'(phase)]++;
			for (int i = 0; i < 11; i++) begin
				got[i] += int'(strobeVec[i]);
			end
			if (linkWrite) begin
				linkAt = cyc;
			end
			if (pcWrite) begin
				pcAt = cyc;
			end
			done = instrDone || skipped || badInstr;
			waitCnt = ((phase == ctrlPkg::phFetchWait) || (phase == ctrlPkg::phMemWait)) ?
				waitCnt + 1 : 0;
			cyc++;
		end
		for (int i = 0; i < 8; i++) begin
			ph = ctrlPkg::ctrlPhase_t'(i);
			compareCount({ph.name(), " cycles"}, gotPh[i], expPh[i]);
		end
		for (int i = 0; i < 11; i++) begin
			compareCount({strobeNames[i], " count"}, got[i], exp[i]);
		end
		if (condVal && (expCls == ctrlPkg::clsBranchLink)) begin
			compareCount("pcWrite cycle", pcAt, linkAt + 1);    // PC right after link
		end
	endtask

	task automatic resetTest();
		int errBefore;
		errBefore = errorCount;
		do begin
			@(posedge clk);
			#2;
			comparePhase("phase", phase, ctrlPkg::phReset);
			for (int i = 0; i < 11; i++) begin
				compareBit(strobeNames[i], strobeVec[i], 1'b0);
			end
		end while (!rstN);
		reportTest("reset", errBefore);
	endtask

	task automatic dataProcTest();
		int errBefore;
		errBefore = errorCount;
		runInstr(32'hE2810001, 1'b1, ctrlPkg::clsDataImm);     // ADD immediate
		runInstr(32'hE2910001, 1'b1, ctrlPkg::clsDataImm);     // ADDS immediate
		runInstr(32'hE1A00102, 1'b1, ctrlPkg::clsDataReg);     // MOV, LSL #2
		runInstr(32'hE0510082, 1'b1, ctrlPkg::clsDataReg);     // SUBS, LSL #1
		runInstr(32'hE3100001, 1'b1, ctrlPkg::clsDataTest);    // TST immediate
		runInstr(32'hE1300001, 1'b1, ctrlPkg::clsDataTest);    // TEQ register
		reportTest("data processing", errBefore);
	endtask

	task automatic loadStoreTest();
		int errBefore;
		ctrlPkg::instrWord_t word;
		logic regOff;
		errBefore = errorCount;
		for (int n = 0; n < 16; n++) begin
			word = $urandom;
			regOff = n[0];     // Alternate immediate and register offset
			word[31:25] = {4'hE, 2'b01, regOff};
			if (regOff) begin
				word[`CU_SHREG_BIT] = 1'b0;
			end
			runInstr(word, 1'b1, word[`CU_SBIT] ? ctrlPkg::clsLoad : ctrlPkg::clsStore);
		end
		reportTest("load and store", errBefore);
	endtask

	task automatic branchTest();
		int errBefore;
		errBefore = errorCount;
		runInstr(32'hEA000010, 1'b1, ctrlPkg::clsBranch);
		runInstr(32'hEB000010, 1'b1, ctrlPkg::clsBranchLink);
		reportTest("branch", errBefore);
	endtask

	task automatic skipTest();
		int errBefore;
		errBefore = errorCount;
		runInstr(32'hE2810001, 1'b0, ctrlPkg::clsDataImm);
		runInstr(32'hE5912004, 1'b0, ctrlPkg::clsLoad);
		runInstr(32'hEB000010, 1'b0, ctrlPkg::clsBranchLink);
		reportTest("condition failed", errBefore);
	endtask

	task automatic unsupportedTest();
		int errBefore;
		errBefore = errorCount;
		runInstr(32'hE0810312, 1'b1, ctrlPkg::clsUnsupported);    // Shift by register
		runInstr(32'hE8900006, 1'b1, ctrlPkg::clsUnsupported);    // LDM
		runInstr(32'hE1D000B0, 1'b1, ctrlPkg::clsUnsupported);    // LDRH
		runInstr(32'hE6000010, 1'b1, ctrlPkg::clsUnsupported);    // Media space
		reportTest("unsupported", errBefore);
	endtask

	initial begin
		#(timeoutNs);
		$display("timeout: the DUT did not finish its instructions within %0d ns", timeoutNs);
		$display("Errors found");
		$finish;
	end

	initial begin
		instrWord = '0;
		moc = 1'b0;
		cond = 1'b1;
		void'($urandom(32'hd662d237));
		resetTest();
		dataProcTest();
		loadStoreTest();
		branchTest();
		skipTest();
		unsupportedTest();
		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+common
common/ctrlPkg.sv
hdl/controlSequencer.sv
hdl/stepCounter.sv
decode/instrDecoder.sv
hdl/microOpGen.sv
hdl/ctrlUnit.sv
dv/tbClock.sv
dv/ctrlUnit_sva.sv
dv/ctrlUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ctrlUnitTb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FILELIST  ?= sources.f

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard common/*.sv common/*.svh hdl/*.sv decode/*.sv dv/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
